/* flist.f */
verilog/icache_pkg.sv
verilog/axi_rd_pkg.sv
verilog/icache_store.sv
verilog/icache_flush_ctrl.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb -f flist.f -o icache_sim

# the run may stop with $fatal, the log decides the result
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi

/* verification/icache_tb.sv */
// instruction cache testbench
`timescale 1ns/1ps

module icache_tb;

    localparam icache_pkg::addr_t SRAM_BASE = 32'h0000_8000;
    localparam icache_pkg::addr_t SRAM_LEN  = 32'h0000_0100;
    localparam int NUM_REQ     = 140;
    localparam int STALL_BOUND = 64;        // cycles per request, worst case
    localparam int CLK_PERIOD  = 4;

    logic clk = 1'b0;
    logic rst, fence_i_i, cpu_arvalid_i, cpu_rready_i;
    icache_pkg::addr_t cpu_araddr_i;
    logic cpu_arready_o, cpu_rvalid_o, hit_o, flush_done_o;
    icache_pkg::word_t cpu_rdata_o;
    logic axi_arvalid_o, axi_arready, axi_rvalid, axi_rready_o, axi_rlast;
    icache_pkg::addr_t axi_araddr_o, mem_rd_addr;
    axi_rd_pkg::axlen_t axi_arlen_o;
    axi_rd_pkg::axsize_t axi_arsize_o;
    axi_rd_pkg::axburst_t axi_arburst_o;
    icache_pkg::word_t axi_rdata, mem_rd_word;
    logic ar_stall, r_stall;

    // reference cache model
    logic              m_valid [2];
    icache_pkg::tag_t  m_tag   [2];
    icache_pkg::word_t m_line  [2][4];

    int          gen;                   // memory generation
    logic [15:0] stim_lfsr  = 16'd84;
    logic [15:0] stall_lfsr = 16'd84;
    int          ar_count, flush_count, exp_flush;
    logic        outstanding, flush_pending;
    icache_pkg::addr_t   next_addr;     // request waiting on the cpu port
    icache_pkg::addr_t   last_ar_addr;
    axi_rd_pkg::axlen_t  last_ar_len;
    axi_rd_pkg::axsize_t last_ar_size;
    axi_rd_pkg::axburst_t last_ar_burst;

    always #(CLK_PERIOD / 2) clk = ~clk;

    icache_top #(
        .SRAM_BASE_ADDR (SRAM_BASE),
        .SRAM_SIZE      (SRAM_LEN)
    ) i_icache_top (
        .clk (clk), .rst (rst), .fence_i_i (fence_i_i),
        .cpu_arvalid_i (cpu_arvalid_i), .cpu_arready_o (cpu_arready_o),
        .cpu_araddr_i (cpu_araddr_i), .cpu_rvalid_o (cpu_rvalid_o),
        .cpu_rready_i (cpu_rready_i), .cpu_rdata_o (cpu_rdata_o),
        .axi_arvalid_o (axi_arvalid_o), .axi_arready_i (axi_arready),
        .axi_araddr_o (axi_araddr_o), .axi_arlen_o (axi_arlen_o),
        .axi_arsize_o (axi_arsize_o), .axi_arburst_o (axi_arburst_o),
        .axi_rvalid_i (axi_rvalid), .axi_rready_o (axi_rready_o),
        .axi_rdata_i (axi_rdata), .axi_rlast_i (axi_rlast),
        .hit_o (hit_o), .flush_done_o (flush_done_o)
    );

    icache_mem_model i_mem (
        .clk (clk), .rst (rst),
        .arvalid_i (axi_arvalid_o), .arready_o (axi_arready),
        .araddr_i (axi_araddr_o), .arlen_i (axi_arlen_o),
        .rvalid_o (axi_rvalid), .rready_i (axi_rready_o),
        .rdata_o (axi_rdata), .rlast_o (axi_rlast),
        .ar_stall_i (ar_stall), .r_stall_i (r_stall),
        .rd_addr_o (mem_rd_addr), .rd_word_i (mem_rd_word)
    );

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // memory content, mixes the whole address with the generation
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a, input int g);
        return (a * 32'h9e37_79b1) ^ {g[7:0], 24'h3ca5c3};
    endfunction

    // fetch address from a small pool, sets collide
    function automatic icache_pkg::addr_t pick_fetch_addr();
        icache_pkg::addr_t bases [8] = '{32'h1000, 32'h2000, 32'h1010, 32'h3010,
                                         32'h4000, 32'h5010, 32'h8000, 32'h80f0};
        logic [4:0] pick;

        for (int i = 0; i < 5; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            pick[i] = stim_lfsr[0];
        end
        return bases[pick[4:2]] + {pick[1:0], 2'b00};
    endfunction

    assign mem_rd_word = mem_word(mem_rd_addr, gen);

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("mismatch %s expected %h actual %h", test, exp, act));
    endtask

    // stall bits for the bus model and the cpu response side
    always @(posedge clk) begin
        stall_lfsr = lfsr_next(stall_lfsr);
        ar_stall <= stall_lfsr[0];
        stall_lfsr = lfsr_next(stall_lfsr);
        r_stall <= stall_lfsr[0];
        stall_lfsr = lfsr_next(stall_lfsr);
        cpu_rready_i <= stall_lfsr[0];
    end

    // bus address phases, flush pulses and request ordering
    always @(posedge clk) begin
        if (!rst) begin
            assert (!(cpu_arready_o && (outstanding || flush_pending)))
                else stop_run("cpu_arready_o pulsed during a flush or an open request");
            if (axi_arvalid_o && axi_arready) begin
                ar_count++;
                last_ar_addr  = axi_araddr_o;
                last_ar_len   = axi_arlen_o;
                last_ar_size  = axi_arsize_o;
                last_ar_burst = axi_arburst_o;
            end
            if (flush_done_o) begin
                flush_count++;
                flush_pending = 1'b0;
            end
            if (cpu_arvalid_i && cpu_arready_o) outstanding = 1'b1;
            if (cpu_rvalid_o && cpu_rready_i) outstanding = 1'b0;
        end
    end

    task automatic run_request(input string name);
        icache_pkg::addr_t addr, exp_araddr;
        logic bypass, pred_hit, hit_seen, got;
        int idx, ar_start;
        icache_pkg::word_t exp, first;

        // only the first request finds the port empty
        if (!cpu_arvalid_i) begin
            next_addr = pick_fetch_addr();
            cpu_arvalid_i <= 1'b1;
            cpu_araddr_i  <= next_addr;
        end
        addr   = next_addr;
        bypass = (addr >= SRAM_BASE) && (addr - SRAM_BASE < SRAM_LEN);
        idx    = addr[4];
        pred_hit = !bypass && m_valid[idx] && (m_tag[idx] == addr[31:5]);
        exp    = pred_hit ? m_line[idx][addr[3:2]] : mem_word(addr, gen);
        exp_araddr = bypass ? addr : {addr[31:4], 4'h0};
        ar_start = ar_count;

        do @(posedge clk); while (!cpu_arready_o);

        // next request stays valid on the port while this one is open
        next_addr = pick_fetch_addr();
        cpu_araddr_i <= next_addr;

        hit_seen = 1'b0;
        got = 1'b0;
        forever begin
            @(posedge clk);
            if (hit_o && !cpu_rvalid_o) hit_seen = 1'b1;
            if (cpu_rvalid_o) begin
                if (!got) first = cpu_rdata_o;
                got = 1'b1;
                assert (cpu_rdata_o == first)
                    else report_mismatch({name, " hold"}, first, cpu_rdata_o);
                if (cpu_rready_i) break;
            end
        end

        assert (cpu_rdata_o == exp) else report_mismatch({name, " data"}, exp, cpu_rdata_o);
        assert (hit_seen == pred_hit) else report_mismatch({name, " hit"}, pred_hit, hit_seen);
        assert (ar_count - ar_start == (pred_hit ? 0 : 1))
            else report_mismatch({name, " phases"}, !pred_hit, ar_count - ar_start);
        if (!pred_hit) begin
            assert (last_ar_addr == exp_araddr)
                else report_mismatch({name, " araddr"}, exp_araddr, last_ar_addr);
            assert (last_ar_len == (bypass ? axi_rd_pkg::LEN_SINGLE : axi_rd_pkg::LEN_LINE))
                else report_mismatch({name, " arlen"}, bypass ? 0 : 3, last_ar_len);
            assert (last_ar_size == axi_rd_pkg::SIZE_WORD &&
                    last_ar_burst == axi_rd_pkg::BURST_INCR)
                else report_mismatch({name, " size burst"},
                                     {axi_rd_pkg::SIZE_WORD, axi_rd_pkg::BURST_INCR},
                                     {last_ar_size, last_ar_burst});
        end

        // a cacheable miss loads the whole current line
        if (!bypass && !pred_hit) begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = addr[31:5];
            for (int w = 0; w < 4; w++) m_line[idx][w] = mem_word({addr[31:4], 4'h0} + w * 4, gen);
        end
    endtask

    task automatic send_fence();
        fence_i_i <= 1'b1;
        flush_pending = 1'b1;
        m_valid = '{1'b0, 1'b0};
        exp_flush++;
        @(posedge clk);
        fence_i_i <= 1'b0;              // next request waits behind the flush
    endtask

    initial begin
        #(NUM_REQ * STALL_BOUND * CLK_PERIOD);
        stop_run("timeout, the cache stopped answering requests");
    end

    initial begin
        rst = 1'b1;
        fence_i_i = 1'b0;
        cpu_arvalid_i = 1'b0;
        cpu_araddr_i = '0;
        cpu_rready_i = 1'b0;
        ar_stall = 1'b0;
        r_stall = 1'b0;
        m_valid = '{1'b0, 1'b0};
        gen = 0;
        ar_count = 0;
        flush_count = 0;
        exp_flush = 0;
        outstanding = 1'b0;
        flush_pending = 1'b0;
        next_addr = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        repeat (40) run_request("warm");
        gen = 1;                        // cached lines go stale
        repeat (30) run_request("stale");
        send_fence();
        repeat (40) run_request("after_fence");
        gen = 2;
        send_fence();
        repeat (30) run_request("second_fence");

        assert (flush_count == exp_flush)
            else report_mismatch("flush_done", exp_flush, flush_count);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verification/icache_mem_model.sv */
// read bus slave model
`timescale 1ns/1ps

module icache_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    input  icache_pkg::addr_t    araddr_i,
    input  axi_rd_pkg::axlen_t   arlen_i,
    output logic                 rvalid_o,
    input  logic                 rready_i,
    output icache_pkg::word_t    rdata_o,
    output logic                 rlast_o,
    // stall controls from the testbench
    input  logic                 ar_stall_i,
    input  logic                 r_stall_i,
    // memory content lookup
    output icache_pkg::addr_t    rd_addr_o,
    input  icache_pkg::word_t    rd_word_i
);

    logic                busy;          // burst in progress
    icache_pkg::addr_t   beat_addr;
    axi_rd_pkg::axlen_t  beats_left;

    assign arready_o = arvalid_i && !busy && !ar_stall_i;
    assign rvalid_o  = busy && !r_stall_i;
    assign rlast_o   = busy && (beats_left == '0);
    assign rd_addr_o = beat_addr;
    assign rdata_o   = rd_word_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (arvalid_i && arready_o) begin
                busy       <= 1'b1;
                beat_addr  <= araddr_i;
                beats_left <= arlen_i;
            end
        end else if (rvalid_o && rready_i) begin
            beat_addr <= beat_addr + 32'd4;     // incrementing burst
            if (beats_left == '0) begin
                busy <= 1'b0;
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

endmodule

/* verilog/icache_top.sv */
// instruction cache top level
`timescale 1ns/1ps

module icache_top #(
    parameter icache_pkg::addr_t SRAM_BASE_ADDR = 32'h0f00_0000,
    parameter icache_pkg::addr_t SRAM_SIZE      = 32'h00ff_ffff
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fence_i_i,
    // cpu fetch port
    input  logic                 cpu_arvalid_i,
    output logic                 cpu_arready_o,
    input  icache_pkg::addr_t    cpu_araddr_i,
    output logic                 cpu_rvalid_o,
    input  logic                 cpu_rready_i,
    output icache_pkg::word_t    cpu_rdata_o,
    // read bus
    output logic                 axi_arvalid_o,
    input  logic                 axi_arready_i,
    output icache_pkg::addr_t    axi_araddr_o,
    output axi_rd_pkg::axlen_t   axi_arlen_o,
    output axi_rd_pkg::axsize_t  axi_arsize_o,
    output axi_rd_pkg::axburst_t axi_arburst_o,
    input  logic                 axi_rvalid_i,
    output logic                 axi_rready_o,
    input  icache_pkg::word_t    axi_rdata_i,
    input  logic                 axi_rlast_i,
    output logic                 hit_o,
    output logic                 flush_done_o
);

    // controller to storage
    icache_pkg::addr_t     lookup_addr;
    logic                  lookup_hit;
    icache_pkg::word_t     lookup_word;
    logic                  fill_we;
    icache_pkg::word_sel_t fill_beat;
    icache_pkg::word_t     fill_word;
    logic                  fill_done;

    // flush path
    logic                  inv_en;
    icache_pkg::index_t    inv_index;
    logic                  ctrl_idle;
    logic                  flush_busy;

    icache_ctrl #(
        .SRAM_BASE_ADDR (SRAM_BASE_ADDR),
        .SRAM_SIZE      (SRAM_SIZE)
    ) i_icache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_arvalid_i  (cpu_arvalid_i),
        .cpu_arready_o  (cpu_arready_o),
        .cpu_araddr_i   (cpu_araddr_i),
        .cpu_rvalid_o   (cpu_rvalid_o),
        .cpu_rready_i   (cpu_rready_i),
        .cpu_rdata_o    (cpu_rdata_o),
        .axi_arvalid_o  (axi_arvalid_o),
        .axi_arready_i  (axi_arready_i),
        .axi_araddr_o   (axi_araddr_o),
        .axi_arlen_o    (axi_arlen_o),
        .axi_arsize_o   (axi_arsize_o),
        .axi_arburst_o  (axi_arburst_o),
        .axi_rvalid_i   (axi_rvalid_i),
        .axi_rready_o   (axi_rready_o),
        .axi_rdata_i    (axi_rdata_i),
        .axi_rlast_i    (axi_rlast_i),
        .hit_o          (hit_o),
        .flush_busy_i   (flush_busy),
        .ctrl_idle_o    (ctrl_idle),
        .lookup_addr_o  (lookup_addr),
        .lookup_hit_i   (lookup_hit),
        .lookup_word_i  (lookup_word),
        .fill_we_o      (fill_we),
        .fill_beat_o    (fill_beat),
        .fill_word_o    (fill_word),
        .fill_done_o    (fill_done)
    );

    icache_store i_icache_store (
        .clk            (clk),
        .rst            (rst),
        .lookup_addr_i  (lookup_addr),
        .lookup_hit_o   (lookup_hit),
        .lookup_word_o  (lookup_word),
        .fill_we_i      (fill_we),
        .fill_beat_i    (fill_beat),
        .fill_word_i    (fill_word),
        .fill_done_i    (fill_done),
        .inv_en_i       (inv_en),
        .inv_index_i    (inv_index)
    );

    icache_flush_ctrl i_icache_flush_ctrl (
        .clk            (clk),
        .rst            (rst),
        .fence_i_i      (fence_i_i),
        .ctrl_idle_i    (ctrl_idle),
        .flush_busy_o   (flush_busy),
        .inv_en_o       (inv_en),
        .inv_index_o    (inv_index),
        .flush_done_o   (flush_done_o)
    );

endmodule

/* verilog/icache_ctrl.sv */
// fetch request controller
`timescale 1ns/1ps

module icache_ctrl #(
    parameter icache_pkg::addr_t SRAM_BASE_ADDR = 32'h0f00_0000,
    parameter icache_pkg::addr_t SRAM_SIZE      = 32'h00ff_ffff
) (
    input  logic                  clk,
    input  logic                  rst,
    // cpu fetch port
    input  logic                  cpu_arvalid_i,
    output logic                  cpu_arready_o,
    input  icache_pkg::addr_t     cpu_araddr_i,
    output logic                  cpu_rvalid_o,
    input  logic                  cpu_rready_i,
    output icache_pkg::word_t     cpu_rdata_o,
    // read bus
    output logic                  axi_arvalid_o,
    input  logic                  axi_arready_i,
    output icache_pkg::addr_t     axi_araddr_o,
    output axi_rd_pkg::axlen_t    axi_arlen_o,
    output axi_rd_pkg::axsize_t   axi_arsize_o,
    output axi_rd_pkg::axburst_t  axi_arburst_o,
    input  logic                  axi_rvalid_i,
    output logic                  axi_rready_o,
    input  icache_pkg::word_t     axi_rdata_i,
    input  logic                  axi_rlast_i,
    output logic                  hit_o,
    // flush handshake
    input  logic                  flush_busy_i,
    output logic                  ctrl_idle_o,
    // storage side
    output icache_pkg::addr_t     lookup_addr_o,
    input  logic                  lookup_hit_i,
    input  icache_pkg::word_t     lookup_word_i,
    output logic                  fill_we_o,
    output icache_pkg::word_sel_t fill_beat_o,
    output icache_pkg::word_t     fill_word_o,
    output logic                  fill_done_o
);

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        LINE_ADDR,
        LINE_DATA,
        LINE_FILL,
        BYPASS_ADDR,
        BYPASS_DATA,
        RESPOND
    } state_t;

    state_t                state;
    icache_pkg::addr_t     req_addr;
    icache_pkg::word_sel_t beat_cnt;
    icache_pkg::addr_t     line_addr;
    logic                  accept;
    logic                  in_window;
    logic                  beat_take;

    // uncached sram window
    assign in_window = (cpu_araddr_i >= SRAM_BASE_ADDR) &&
                       ((cpu_araddr_i - SRAM_BASE_ADDR) < SRAM_SIZE);

    assign accept    = (state == IDLE) && cpu_arready_o && cpu_arvalid_i;
    assign beat_take = axi_rvalid_i && axi_rready_o;
    assign line_addr = {req_addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS],
                        {icache_pkg::OFFSET_BITS{1'b0}}};

    assign lookup_addr_o = req_addr;
    assign ctrl_idle_o   = (state == IDLE) && !cpu_arready_o;
    assign hit_o         = (state == CHECK) && lookup_hit_i;   // rvalid rises next cycle

    // fill beats go straight into the line
    assign fill_we_o   = (state == LINE_DATA) && beat_take;
    assign fill_beat_o = beat_cnt;
    assign fill_word_o = axi_rdata_i;
    assign fill_done_o = fill_we_o && axi_rlast_i;

    assign axi_arsize_o  = axi_rd_pkg::SIZE_WORD;
    assign axi_arburst_o = axi_rd_pkg::BURST_INCR;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            cpu_arready_o <= 1'b0;
            cpu_rvalid_o  <= 1'b0;
            axi_arvalid_o <= 1'b0;
            axi_rready_o  <= 1'b0;
            beat_cnt      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        cpu_arready_o <= 1'b0;
                        if (in_window) begin
                            axi_arvalid_o <= 1'b1;
                            state         <= BYPASS_ADDR;
                        end else begin
                            state <= CHECK;
                        end
                    end else begin
                        // one-cycle ready pulse, none while flushing
                        cpu_arready_o <= cpu_arvalid_i && !flush_busy_i && !cpu_arready_o;
                    end
                end
                CHECK: begin
                    if (lookup_hit_i) begin
                        cpu_rvalid_o <= 1'b1;
                        state        <= RESPOND;
                    end else begin
                        axi_arvalid_o <= 1'b1;
                        state         <= LINE_ADDR;
                    end
                end
                LINE_ADDR: begin
                    if (axi_arready_i) begin
                        axi_arvalid_o <= 1'b0;
                        axi_rready_o  <= 1'b1;
                        beat_cnt      <= '0;
                        state         <= LINE_DATA;
                    end
                end
                LINE_DATA: begin
                    if (beat_take) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi_rlast_i) begin
                            axi_rready_o <= 1'b0;
                            state        <= LINE_FILL;
                        end
                    end
                end
                LINE_FILL: begin
                    cpu_rvalid_o <= 1'b1;           // word re-read from the new line
                    state        <= RESPOND;
                end
                BYPASS_ADDR: begin
                    if (axi_arready_i) begin
                        axi_arvalid_o <= 1'b0;
                        axi_rready_o  <= 1'b1;
                        state         <= BYPASS_DATA;
                    end
                end
                BYPASS_DATA: begin
                    if (beat_take) begin
                        axi_rready_o <= 1'b0;
                        cpu_rvalid_o <= 1'b1;
                        state        <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (cpu_rready_i) begin
                        cpu_rvalid_o <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request address, bus address and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= cpu_araddr_i;
            if (in_window) begin
                axi_araddr_o <= cpu_araddr_i;       // exact word
                axi_arlen_o  <= axi_rd_pkg::LEN_SINGLE;
            end
        end
        if (state == CHECK && !lookup_hit_i) begin
            axi_araddr_o <= line_addr;
            axi_arlen_o  <= axi_rd_pkg::LEN_LINE;
        end
        if ((state == CHECK && lookup_hit_i) || state == LINE_FILL) begin
            cpu_rdata_o <= lookup_word_i;
        end else if (state == BYPASS_DATA && beat_take) begin
            cpu_rdata_o <= axi_rdata_i;
        end
    end

endmodule

/* verilog/icache_flush_ctrl.sv */
// fence flush sequencer
`timescale 1ns/1ps

module icache_flush_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               fence_i_i,
    input  logic               ctrl_idle_i,
    output logic               flush_busy_o,
    output logic               inv_en_o,
    output icache_pkg::index_t inv_index_o,
    output logic               flush_done_o
);

    logic               pending;     // fence seen, walk not started
    logic               walking;
    icache_pkg::index_t walk_index;
    logic               last_set;

    assign last_set = (walk_index == icache_pkg::index_t'(icache_pkg::NUM_SETS - 1));

    assign flush_busy_o = fence_i_i || pending || walking;
    assign inv_en_o     = walking;
    assign inv_index_o  = walk_index;
    assign flush_done_o = walking && last_set;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            walking    <= 1'b0;
            walk_index <= '0;
        end else begin
            if (walking) begin
                if (last_set) begin
                    walking <= 1'b0;
                end else begin
                    walk_index <= walk_index + 1'b1;
                end
            end else if (pending && ctrl_idle_i) begin
                walking    <= 1'b1;             // start from set 0
                walk_index <= '0;
            end

            // a fence during the walk queues another one
            if (fence_i_i) begin
                pending <= 1'b1;
            end else if (!walking && ctrl_idle_i) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

/* verilog/icache_store.sv */
// cache tag and line storage
`timescale 1ns/1ps

module icache_store (
    input  logic                  clk,
    input  logic                  rst,
    // lookup
    input  icache_pkg::addr_t     lookup_addr_i,
    output logic                  lookup_hit_o,
    output icache_pkg::word_t     lookup_word_o,
    // line fill
    input  logic                  fill_we_i,
    input  icache_pkg::word_sel_t fill_beat_i,
    input  icache_pkg::word_t     fill_word_i,
    input  logic                  fill_done_i,
    // invalidation
    input  logic                  inv_en_i,
    input  icache_pkg::index_t    inv_index_i
);

    icache_pkg::tag_t  tags  [icache_pkg::NUM_SETS];
    icache_pkg::line_t lines [icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_SETS-1:0] valid;

    icache_pkg::tag_t      addr_tag;
    icache_pkg::index_t    addr_index;
    icache_pkg::word_sel_t addr_word;

    // address split
    assign addr_tag   = lookup_addr_i[icache_pkg::ADDR_BITS-1 -: icache_pkg::TAG_BITS];
    assign addr_index = lookup_addr_i[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
    assign addr_word  = lookup_addr_i[icache_pkg::OFFSET_BITS-1 -: $bits(icache_pkg::word_sel_t)];

    assign lookup_hit_o  = valid[addr_index] && (tags[addr_index] == addr_tag);
    assign lookup_word_o = lines[addr_index][addr_word*icache_pkg::WORD_BITS +: icache_pkg::WORD_BITS];

    // valid bits, invalidation wins over a fill
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (inv_en_i) begin
            valid[inv_index_i] <= 1'b0;
        end else if (fill_done_i) begin
            valid[addr_index] <= 1'b1;                  // last beat written
        end
    end

    // line data and tags
    always_ff @(posedge clk) begin
        if (!inv_en_i) begin
            if (fill_we_i) begin
                lines[addr_index][fill_beat_i*icache_pkg::WORD_BITS +: icache_pkg::WORD_BITS]
                    <= fill_word_i;
            end
            if (fill_done_i) begin
                tags[addr_index] <= addr_tag;
            end
        end
    end

endmodule

/* verilog/axi_rd_pkg.sv */
// read bus burst fields
package axi_rd_pkg;

    // address phase field types
    typedef logic [7:0] axlen_t;        // beats minus one
    typedef logic [2:0] axsize_t;       // log2 of bytes per beat
    typedef logic [1:0] axburst_t;

    // burst lengths
    localparam axlen_t LEN_LINE   = 8'd3;    // four beats, one full line
    localparam axlen_t LEN_SINGLE = 8'd0;

    // beat size
    localparam axsize_t SIZE_WORD = 3'd2;    // four bytes

    // incrementing burst
    localparam axburst_t BURST_INCR = 2'd1;

endpackage

/* verilog/icache_pkg.sv */
// instruction cache geometry
package icache_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int NUM_SETS       = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 4;                   // 16-byte lines
    localparam int INDEX_BITS     = $clog2(NUM_SETS);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    // byte address and instruction word
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [WORD_BITS-1:0] word_t;

    // whole line, word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

    // address fields
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;   // addr bits 3..2

endpackage
